// ==== hw/mmu_pkg.sv ====
/*
 * Shared widths, address field helpers and the walker state encoding of the MMU.
 * SATP mode sits in bits 63:60 and ASID in 59:44. Mode zero is bare.
 * Page offsets are fixed at 4 KiB. Superpages are not modelled.
 */
`default_nettype none

package mmu_pkg;

    localparam int PAGE_OFFSET_W = 12;
    localparam int FLUSH_W       = 256;    // one bit per request ID

    typedef logic [63:0] vaddr_t;
    typedef logic [63:0] paddr_t;
    typedef logic [63:0] satp_t;
    typedef logic [15:0] asid_t;
    typedef logic [51:0] vpn_t;
    typedef logic [51:0] ppn_t;
    typedef logic [7:0]  perm_t;           // zero is a page fault
    typedef logic [7:0]  rqst_id_t;        // zero is idle
    typedef logic [67:0] tlb_tag_t;        // asid above vpn
    typedef logic [2:0]  fence_t;          // all asid, all addr, valid

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_READ,
        WALK_CHECK,
        WALK_RESPOND
    } walk_state_t;

    function automatic vpn_t va_vpn(vaddr_t va);
        return va[63:PAGE_OFFSET_W];
    endfunction

    function automatic ppn_t pa_ppn(paddr_t pa);
        return pa[63:PAGE_OFFSET_W];
    endfunction

    function automatic asid_t satp_asid(satp_t satp);
        return satp[59:44];
    endfunction

    function automatic logic satp_bare(satp_t satp);
        return satp[63:60] == 4'd0;
    endfunction

    function automatic tlb_tag_t make_tag(asid_t asid, vpn_t vpn);
        return {asid, vpn};
    endfunction

    function automatic asid_t tag_asid(tlb_tag_t tag);
        return tag[67:52];
    endfunction

    function automatic vpn_t tag_vpn(tlb_tag_t tag);
        return tag[51:0];
    endfunction

endpackage

`default_nettype wire

// ==== hw/xlat_if.sv ====
/*
 * Translation link between the TLB and the page walker.
 * A nonzero rqst is held with vadd and satp until resp returns the same ID.
 * resp is nonzero for one cycle per walk.
 */
`timescale 1ns/10ps
`default_nettype none

interface xlat_if import mmu_pkg::*; ();

    rqst_id_t rqst;    // walk request ID
    vaddr_t   vadd;
    satp_t    satp;
    rqst_id_t resp;    // walk response ID
    perm_t    perm;    // zero on fault
    paddr_t   padd;

    modport requester (
        output rqst,
        output vadd,
        output satp,
        input  resp,
        input  perm,
        input  padd
    );

    modport responder (
        input  rqst,
        input  vadd,
        input  satp,
        output resp,
        output perm,
        output padd
    );

endinterface

`default_nettype wire

// ==== hw/pte_ram.sv ====
/*
 * Direct-mapped page table, one entry per VPN low bits.
 * A write is visible to a read on the next edge. Entries cannot be invalidated
 * except by reset; write perm zero to make a page fault.
 */
`timescale 1ns/10ps
`default_nettype none

module pte_ram import mmu_pkg::*; #(
    parameter int pt_aw = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  logic [pt_aw-1:0] wr_addr,
    input  vpn_t             wr_vpn,
    input  asid_t            wr_asid,
    input  ppn_t             wr_ppn,
    input  perm_t            wr_perm,
    input  logic [pt_aw-1:0] rd_addr,
    output tlb_tag_t         rd_tag,
    output ppn_t             rd_ppn,
    output perm_t            rd_perm,
    output logic             rd_valid
);

    localparam int DEPTH = 1 << pt_aw;

    logic [DEPTH-1:0] vld;
    tlb_tag_t         tag_mem  [DEPTH];
    ppn_t             ppn_mem  [DEPTH];
    perm_t            perm_mem [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            vld      <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (we)
                vld[wr_addr] <= 1'b1;
            rd_valid <= vld[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_addr]  <= make_tag(wr_asid, wr_vpn);
            ppn_mem[wr_addr]  <= wr_ppn;
            perm_mem[wr_addr] <= wr_perm;
        end
        rd_tag  <= tag_mem[rd_addr];     // old data on same-edge write
        rd_ppn  <= ppn_mem[rd_addr];
        rd_perm <= perm_mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/page_walker.sv ====
/*
 * Single-level page walker over a direct-mapped page table.
 * Response comes walk_delay+2 cycles after a request is taken.
 * A new request is taken only after rqst has gone back to zero.
 */
`timescale 1ns/10ps
`default_nettype none

module page_walker import mmu_pkg::*; #(
    parameter int pt_aw      = 6,
    parameter int walk_delay = 2
) (
    input  logic             clk,
    input  logic             rst,
    xlat_if.responder        x,
    output logic [pt_aw-1:0] rd_addr,
    input  tlb_tag_t         rd_tag,
    input  ppn_t             rd_ppn,
    input  perm_t            rd_perm,
    input  logic             rd_valid
);

    localparam int CNT_W = $clog2(walk_delay + 2);

    walk_state_t      state;
    logic [CNT_W-1:0] wait_cnt;
    logic             hold;      // requester still shows the old rqst
    rqst_id_t         req_id;
    vaddr_t           req_vadd;
    asid_t            req_asid;
    vpn_t             req_vpn;
    ppn_t             res_ppn;
    perm_t            res_perm;
    logic             pte_match;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WALK_IDLE;
            wait_cnt <= '0;
            hold     <= 1'b0;
        end else begin
            unique case (state)
                WALK_IDLE: begin
                    if (hold) begin
                        hold <= x.rqst != '0;
                    end else if (x.rqst != '0) begin
                        state    <= WALK_READ;
                        wait_cnt <= '0;
                    end
                end
                WALK_READ: begin
                    if (wait_cnt == CNT_W'(walk_delay))
                        state <= WALK_CHECK;
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                WALK_CHECK: state <= WALK_RESPOND;
                WALK_RESPOND: begin
                    state <= WALK_IDLE;
                    hold  <= 1'b1;
                end
                default: state <= WALK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WALK_IDLE && !hold && x.rqst != '0) begin
            req_id   <= x.rqst;
            req_vadd <= x.vadd;
            req_asid <= satp_asid(x.satp);
        end
        if (state == WALK_CHECK) begin
            res_ppn  <= rd_ppn;
            res_perm <= pte_match ? rd_perm : '0;   // miss in table is a fault
        end
    end

    assign req_vpn   = va_vpn(req_vadd);
    assign rd_addr   = req_vpn[pt_aw-1:0];
    assign pte_match = rd_valid && rd_tag == make_tag(req_asid, req_vpn);

    assign x.resp = (state == WALK_RESPOND) ? req_id : '0;
    assign x.perm = res_perm;
    assign x.padd = {res_ppn, req_vadd[PAGE_OFFSET_W-1:0]};

endmodule

`default_nettype wire

// ==== hw/tlb.sv ====
/*
 * Set-associative TLB with FIFO replacement and a single MSHR.
 * sets and ways must be powers of two, both at least 2.
 * Lowest channel wins the MSHR, so a busy channel 0 can starve the others.
 * Requests sampled on the edge after a fence see stale entries.
 */
`timescale 1ns/10ps
`default_nettype none

module tlb import mmu_pkg::*; #(
    parameter int chn  = 2,
    parameter int sets = 16,
    parameter int ways = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [FLUSH_W-1:0] flush,
    input  fence_t             fence,
    input  asid_t              fasid,
    input  vaddr_t             fvadd,
    input  rqst_id_t [chn-1:0] s_rqst,
    input  vaddr_t   [chn-1:0] s_vadd,
    input  satp_t    [chn-1:0] s_satp,
    output rqst_id_t [chn-1:0] s_resp,
    output perm_t    [chn-1:0] s_perm,
    output paddr_t   [chn-1:0] s_padd,
    xlat_if.requester          m
);

    localparam int IDX_W = $clog2(sets);
    localparam int WAY_W = $clog2(ways);
    localparam int CHN_W = (chn > 1) ? $clog2(chn) : 1;

    tlb_tag_t         tag_mem  [sets][ways];
    ppn_t             ppn_mem  [sets][ways];
    perm_t            perm_mem [sets][ways];
    logic [ways-1:0]  vld      [sets];
    logic [WAY_W-1:0] fifo_ptr [sets];     // next way to replace

    rqst_id_t [chn-1:0] b_rqst;            // buffered channel requests
    vaddr_t   [chn-1:0] b_vadd;
    satp_t    [chn-1:0] b_satp;
    tlb_tag_t           set_tag  [chn][ways];
    ppn_t               set_ppn  [chn][ways];
    perm_t              set_perm [chn][ways];
    logic [ways-1:0]    set_vld  [chn];

    logic [chn-1:0]   ch_hit;
    logic [chn-1:0]   ch_bare;
    logic [chn-1:0]   ch_miss;
    logic [WAY_W-1:0] ch_way [chn];

    rqst_id_t         mis_req;             // zero once answered or flushed
    logic             mis_busy;
    logic             mis_done;            // one spare cycle after the walk
    vaddr_t           mis_vadd;
    satp_t            mis_satp;
    logic             cap_en;
    logic [CHN_W-1:0] cap_sel;
    logic             walk_ok;
    logic             fill_en;
    logic             fault;
    logic [IDX_W-1:0] widx;

    fence_t           fnc_q;
    asid_t            fasid_q;
    vaddr_t           fvadd_q;
    logic [IDX_W-1:0] fidx;
    logic [ways-1:0]  fnc_clr;

    function automatic logic [IDX_W-1:0] set_index(vaddr_t va);
        return va[PAGE_OFFSET_W +: IDX_W];
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < chn; i++) begin
            if (rst)
                b_rqst[i] <= '0;
            else
                b_rqst[i] <= flush[s_rqst[i]] ? '0 : s_rqst[i];  // cancelled on entry
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < chn; i++) begin
            b_vadd[i]   <= s_vadd[i];
            b_satp[i]   <= s_satp[i];
            set_tag[i]  <= tag_mem[set_index(s_vadd[i])];
            set_ppn[i]  <= ppn_mem[set_index(s_vadd[i])];
            set_perm[i] <= perm_mem[set_index(s_vadd[i])];
            set_vld[i]  <= vld[set_index(s_vadd[i])];
        end
    end

    always_comb begin
        tlb_tag_t want;
        for (int i = 0; i < chn; i++) begin
            want      = make_tag(satp_asid(b_satp[i]), va_vpn(b_vadd[i]));
            ch_hit[i] = 1'b0;
            ch_way[i] = '0;
            for (int w = 0; w < ways; w++) begin
                if (!ch_hit[i] && set_vld[i][w] && set_tag[i][w] == want) begin
                    ch_hit[i] = 1'b1;              // first hitting way
                    ch_way[i] = WAY_W'(w);
                end
            end
            ch_bare[i] = satp_bare(b_satp[i]);
            ch_miss[i] = b_rqst[i] != '0 && !ch_hit[i] && !ch_bare[i];
        end
    end

    assign walk_ok = m.resp != '0 && m.resp == mis_req;
    assign fill_en = walk_ok && m.perm != '0;
    assign fault   = walk_ok && m.perm == '0;

    always_comb begin
        for (int i = 0; i < chn; i++) begin
            s_resp[i] = (ch_hit[i] || ch_bare[i]) ? b_rqst[i] : '0;
            s_perm[i] = ch_bare[i] ? '1 : set_perm[i][ch_way[i]];
            s_padd[i] = ch_bare[i] ? b_vadd[i]
                      : {set_ppn[i][ch_way[i]], b_vadd[i][PAGE_OFFSET_W-1:0]};
            if (fault && b_rqst[i] == mis_req) begin
                s_resp[i] = b_rqst[i];             // fault passed straight through
                s_perm[i] = '0;
            end
        end
    end

    always_comb begin
        cap_en  = 1'b0;
        cap_sel = '0;
        for (int i = chn - 1; i >= 0; i--) begin
            if (ch_miss[i] && !flush[b_rqst[i]]) begin
                cap_en  = 1'b1;
                cap_sel = CHN_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mis_req  <= '0;
            mis_busy <= 1'b0;
            mis_done <= 1'b0;
        end else if (!mis_busy) begin
            if (cap_en) begin
                mis_req  <= b_rqst[cap_sel];
                mis_busy <= 1'b1;
            end
        end else if (mis_done) begin
            mis_busy <= 1'b0;                      // stale misses have drained
            mis_done <= 1'b0;
        end else if (m.resp != '0) begin
            mis_req  <= '0;
            mis_done <= 1'b1;
        end else if (flush[mis_req]) begin
            mis_req <= '0;                         // walk still runs out
        end
    end

    always_ff @(posedge clk) begin
        if (!mis_busy && cap_en) begin
            mis_vadd <= b_vadd[cap_sel];
            mis_satp <= b_satp[cap_sel];
        end
    end

    assign m.rqst = (m.resp != '0) ? '0 : mis_req;
    assign m.vadd = mis_vadd;
    assign m.satp = mis_satp;
    assign widx   = set_index(mis_vadd);

    always_ff @(posedge clk) begin
        if (rst) begin
            fnc_q <= '0;
        end else begin
            fnc_q <= fence;
        end
    end

    always_ff @(posedge clk) begin
        fasid_q <= fasid;
        fvadd_q <= fvadd;
    end

    assign fidx = set_index(fvadd_q);

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            fnc_clr[w] = tag_vpn(tag_mem[fidx][w]) == va_vpn(fvadd_q) &&
                         (fnc_q[2] || tag_asid(tag_mem[fidx][w]) == fasid_q);
        end
    end

    // fence wins over a fill landing on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                vld[s]      <= '0;
                fifo_ptr[s] <= '0;
            end
        end else if (fnc_q[0]) begin
            if (fnc_q[1]) begin
                for (int s = 0; s < sets; s++)
                    vld[s] <= '0;
            end else begin
                vld[fidx] <= vld[fidx] & ~fnc_clr;
            end
        end else if (fill_en) begin
            vld[widx][fifo_ptr[widx]] <= 1'b1;
            fifo_ptr[widx]            <= fifo_ptr[widx] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fnc_q[0] && fill_en) begin
            tag_mem[widx][fifo_ptr[widx]]  <= make_tag(satp_asid(mis_satp), va_vpn(mis_vadd));
            ppn_mem[widx][fifo_ptr[widx]]  <= pa_ppn(m.padd);
            perm_mem[widx][fifo_ptr[widx]] <= m.perm;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mmu_top.sv ====
/*
 * MMU top level: TLB, single-level page walker and page table RAM.
 * Page table is loaded through the pt_* write port only.
 * Keep channel requests idle on the edge after a fence.
 */
`timescale 1ns/10ps
`default_nettype none

module mmu_top import mmu_pkg::*; #(
    parameter int chn        = 2,
    parameter int sets       = 16,
    parameter int ways       = 4,
    parameter int pt_aw      = 6,
    parameter int walk_delay = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  rqst_id_t [chn-1:0] s_rqst,
    input  vaddr_t   [chn-1:0] s_vadd,
    input  satp_t    [chn-1:0] s_satp,
    output rqst_id_t [chn-1:0] s_resp,
    output perm_t    [chn-1:0] s_perm,
    output paddr_t   [chn-1:0] s_padd,
    input  fence_t             fence,
    input  asid_t              fasid,
    input  vaddr_t             fvadd,
    input  logic [FLUSH_W-1:0] flush,
    input  logic               pt_we,
    input  logic [pt_aw-1:0]   pt_addr,
    input  vpn_t               pt_vpn,
    input  asid_t              pt_asid,
    input  ppn_t               pt_ppn,
    input  perm_t              pt_perm
);

    logic [pt_aw-1:0] rd_addr;
    tlb_tag_t         rd_tag;
    ppn_t             rd_ppn;
    perm_t            rd_perm;
    logic             rd_valid;

    xlat_if u_xlat ();

    tlb #(
        .chn  (chn),
        .sets (sets),
        .ways (ways)
    ) u_tlb (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .fence  (fence),
        .fasid  (fasid),
        .fvadd  (fvadd),
        .s_rqst (s_rqst),
        .s_vadd (s_vadd),
        .s_satp (s_satp),
        .s_resp (s_resp),
        .s_perm (s_perm),
        .s_padd (s_padd),
        .m      (u_xlat)
    );

    page_walker #(
        .pt_aw      (pt_aw),
        .walk_delay (walk_delay)
    ) u_walker (
        .clk      (clk),
        .rst      (rst),
        .x        (u_xlat),
        .rd_addr  (rd_addr),
        .rd_tag   (rd_tag),
        .rd_ppn   (rd_ppn),
        .rd_perm  (rd_perm),
        .rd_valid (rd_valid)
    );

    pte_ram #(
        .pt_aw (pt_aw)
    ) u_ram (
        .clk      (clk),
        .rst      (rst),
        .we       (pt_we),
        .wr_addr  (pt_addr),
        .wr_vpn   (pt_vpn),
        .wr_asid  (pt_asid),
        .wr_ppn   (pt_ppn),
        .wr_perm  (pt_perm),
        .rd_addr  (rd_addr),
        .rd_tag   (rd_tag),
        .rd_ppn   (rd_ppn),
        .rd_perm  (rd_perm),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

// ==== dv/tb_model.svh ====
/*
 * Page table shadow, LFSR and expected translations for the MMU testbench.
 * Included inside tb_mmu_top, which must declare PT_AW and import mmu_pkg first.
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic        sh_valid [1 << PT_AW];
vpn_t        sh_vpn   [1 << PT_AW];
asid_t       sh_asid  [1 << PT_AW];
ppn_t        sh_ppn   [1 << PT_AW];
perm_t       sh_perm  [1 << PT_AW];
logic [15:0] lfsr_state;

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v          = {v[62:0], lfsr_state[0]};   // one step per bit
    end
    return v;
endfunction

function automatic perm_t rand_perm();
    return {7'(rand_bits(7)), 1'b1};             // never a fault
endfunction

function automatic perm_t expected_perm(vaddr_t va, satp_t satp);
    int idx;
    idx = int'(va[12 +: PT_AW]);
    if (satp[63:60] == 4'h0)
        return 8'hFF;                            // bare
    if (sh_valid[idx] && sh_vpn[idx] == va[63:12] && sh_asid[idx] == satp[59:44])
        return sh_perm[idx];
    return 8'h00;
endfunction

function automatic paddr_t expected_padd(vaddr_t va, satp_t satp);
    int idx;
    idx = int'(va[12 +: PT_AW]);
    if (satp[63:60] == 4'h0)
        return va;
    return {sh_ppn[idx], va[11:0]};
endfunction

`endif

// ==== dv/tb_mmu_top.sv ====
/*
 * Testbench for mmu_top with two channels and a 64-entry page table.
 * Responses are checked by concurrent assertions against a page table shadow.
 * Each test page sits at its own table slot and TLB set, so nothing is evicted.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_mmu_top import mmu_pkg::*; ();

    localparam int CHN        = 2;
    localparam int PT_AW      = 6;
    localparam int WALK_DELAY = 2;
    localparam int NUM_PAGES  = 8;

    logic               clk;
    logic               rst;
    rqst_id_t [CHN-1:0] s_rqst;
    vaddr_t   [CHN-1:0] s_vadd;
    satp_t    [CHN-1:0] s_satp;
    rqst_id_t [CHN-1:0] s_resp;
    perm_t    [CHN-1:0] s_perm;
    paddr_t   [CHN-1:0] s_padd;
    fence_t             fence;
    asid_t              fasid;
    vaddr_t             fvadd;
    logic [FLUSH_W-1:0] flush;
    logic               pt_we;
    logic [PT_AW-1:0]   pt_addr;
    vpn_t               pt_vpn;
    asid_t              pt_asid;
    ppn_t               pt_ppn;
    perm_t              pt_perm;

    rqst_id_t [CHN-1:0] exp_id;        // only ID a channel may answer with
    perm_t    [CHN-1:0] exp_perm;
    paddr_t   [CHN-1:0] exp_padd;
    logic     [CHN-1:0] must_resp;     // answer due on the edge after next
    rqst_id_t           next_id;
    int                 issued;
    int                 cycles;
    vpn_t               pg_vpn  [NUM_PAGES];
    asid_t              pg_asid [NUM_PAGES];

    `include "tb_model.svh"

    mmu_top #(.chn(CHN), .sets(16), .ways(4), .pt_aw(PT_AW), .walk_delay(WALK_DELAY))
        u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * issued + 200)
                stop_on_error($sformatf("timeout after %0d cycles, %0d requests issued",
                                        cycles, issued));
        end
    end

    for (genvar c = 0; c < CHN; c++) begin : g_check
        a_resp_id: assert property (@(posedge clk) disable iff (rst)
            s_resp[c] == '0 || s_resp[c] == exp_id[c])
            else stop_on_error($sformatf("mismatch s_resp[%0d]: got %h expected %h",
                                         c, $sampled(s_resp[c]), $sampled(exp_id[c])));
        a_resp_perm: assert property (@(posedge clk) disable iff (rst)
            s_resp[c] == '0 || s_perm[c] == exp_perm[c])
            else stop_on_error($sformatf("mismatch s_perm[%0d]: got %h expected %h",
                                         c, $sampled(s_perm[c]), $sampled(exp_perm[c])));
        a_resp_padd: assert property (@(posedge clk) disable iff (rst)
            s_resp[c] == '0 || s_perm[c] == '0 || s_padd[c] == exp_padd[c])
            else stop_on_error($sformatf("mismatch s_padd[%0d]: got %h expected %h",
                                         c, $sampled(s_padd[c]), $sampled(exp_padd[c])));
        a_resp_prompt: assert property (@(posedge clk) disable iff (rst)
            $past(must_resp[c]) |-> s_resp[c] == exp_id[c])
            else stop_on_error($sformatf("request %h on channel %0d not answered in one cycle",
                                         $sampled(exp_id[c]), c));
    end

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic vaddr_t page_va(int p);
        return {pg_vpn[p], 12'(rand_bits(12))};
    endfunction

    function automatic satp_t paged_satp(asid_t asid);
        return {4'h8, asid, 44'h0};
    endfunction

    task automatic write_pte(int p, ppn_t ppn, perm_t perm);
        int idx;
        idx = int'(pg_vpn[p][PT_AW-1:0]);
        @(negedge clk);
        pt_we         = 1'b1;
        pt_addr       = PT_AW'(idx);
        pt_vpn        = pg_vpn[p];
        pt_asid       = pg_asid[p];
        pt_ppn        = ppn;
        pt_perm       = perm;
        sh_valid[idx] = 1'b1;
        sh_vpn[idx]   = pg_vpn[p];
        sh_asid[idx]  = pg_asid[p];
        sh_ppn[idx]   = ppn;
        sh_perm[idx]  = perm;
        @(negedge clk);
        pt_we = 1'b0;
    endtask

    task automatic translate(int c, vaddr_t va, satp_t satp, perm_t perm, paddr_t padd,
                             bit fast);
        rqst_id_t id;
        id      = next_id;
        next_id = next_id + 8'd1;
        @(negedge clk);
        s_rqst[c]    = id;
        s_vadd[c]    = va;
        s_satp[c]    = satp;
        exp_id[c]    = id;
        exp_perm[c]  = perm;
        exp_padd[c]  = padd;
        must_resp[c] = fast;
        issued++;
        @(negedge clk);
        must_resp[c] = 1'b0;
        while (s_resp[c] != id)
            @(negedge clk);
        s_rqst[c] = '0;                  // answered, go idle
    endtask

    task automatic access(int c, vaddr_t va, satp_t satp, bit fast);
        translate(c, va, satp, expected_perm(va, satp), expected_padd(va, satp), fast);
    endtask

    task automatic send_fence(fence_t f, vaddr_t va, asid_t asid);
        @(negedge clk);
        fence = f;
        fvadd = va;
        fasid = asid;
        @(negedge clk);
        fence = '0;
        repeat (2) @(negedge clk);       // channels idle until the clear lands
    endtask

    task automatic flush_walk(int c, vaddr_t va, satp_t satp);
        rqst_id_t id;
        id      = next_id;
        next_id = next_id + 8'd1;
        @(negedge clk);
        s_rqst[c]   = id;
        s_vadd[c]   = va;
        s_satp[c]   = satp;
        exp_id[c]   = '0;                // no answer while the first walk runs
        exp_perm[c] = expected_perm(va, satp);
        exp_padd[c] = expected_padd(va, satp);
        issued++;
        repeat (2) @(negedge clk);       // miss now sits in the MSHR
        flush[id] = 1'b1;
        @(negedge clk);
        flush = '0;
        repeat (WALK_DELAY + 5) @(negedge clk);   // cancelled walk has ended
        exp_id[c] = id;
        while (s_resp[c] != id)
            @(negedge clk);
        s_rqst[c] = '0;
    endtask

    initial begin : main
        vaddr_t va;
        satp_t  satp;
        ppn_t   old_ppn;
        perm_t  old_perm;
        rst = 1'b1;
        s_rqst = '0;
        s_vadd = '0;
        s_satp = '0;
        fence = '0;
        fasid = '0;
        fvadd = '0;
        flush = '0;
        pt_we = 1'b0;
        pt_addr = '0;
        pt_vpn = '0;
        pt_asid = '0;
        pt_ppn = '0;
        pt_perm = '0;
        exp_id = '0;
        exp_perm = '0;
        exp_padd = '0;
        must_resp = '0;
        next_id = 8'd1;
        issued = 0;
        lfsr_state = 16'd22016;
        for (int i = 0; i < (1 << PT_AW); i++)
            sh_valid[i] = 1'b0;
        for (int p = 0; p < NUM_PAGES; p++) begin
            pg_vpn[p]            = vpn_t'(rand_bits(52));
            pg_vpn[p][PT_AW-1:0] = PT_AW'(p);   // slot p of the table
            pg_asid[p]           = asid_t'(rand_bits(16));
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // bare mode on both channels
        va   = rand_bits(64);
        satp = {4'h0, 60'(rand_bits(60))};
        fork
            access(0, va, satp, 1'b1);
            access(1, ~va, satp, 1'b1);
        join

        // two misses at once, then hits
        write_pte(0, ppn_t'(rand_bits(52)), rand_perm());
        write_pte(1, ppn_t'(rand_bits(52)), rand_perm());
        fork
            access(0, page_va(0), paged_satp(pg_asid[0]), 1'b0);
            access(1, page_va(1), paged_satp(pg_asid[1]), 1'b0);
        join
        access(0, page_va(0), paged_satp(pg_asid[0]), 1'b1);
        access(1, page_va(1), paged_satp(pg_asid[1]), 1'b1);

        // unloaded slot and wrong ASID both fault
        fork
            access(0, page_va(2), paged_satp(pg_asid[2]), 1'b0);
            access(1, page_va(0), paged_satp(pg_asid[0] ^ 16'h0001), 1'b0);
        join

        // fence page 0 only, page 1 keeps its cached translation
        old_ppn  = sh_ppn[1];
        old_perm = sh_perm[1];
        write_pte(0, ppn_t'(rand_bits(52)), rand_perm());
        write_pte(1, ppn_t'(rand_bits(52)), rand_perm());
        send_fence(3'b001, page_va(0), pg_asid[0]);
        access(0, page_va(0), paged_satp(pg_asid[0]), 1'b0);
        va = page_va(1);
        translate(1, va, paged_satp(pg_asid[1]), old_perm, {old_ppn, va[11:0]}, 1'b1);

        // fence everything, both pages walk again
        write_pte(0, ppn_t'(rand_bits(52)), rand_perm());
        send_fence(3'b011, '0, '0);
        access(0, page_va(0), paged_satp(pg_asid[0]), 1'b0);
        access(1, page_va(1), paged_satp(pg_asid[1]), 1'b0);

        // flushed walk stays silent until the retry is served
        write_pte(3, ppn_t'(rand_bits(52)), rand_perm());
        flush_walk(0, page_va(3), paged_satp(pg_asid[3]));
        access(0, page_va(3), paged_satp(pg_asid[3]), 1'b1);

        repeat (4) @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
hw/mmu_pkg.sv
hw/xlat_if.sv
hw/pte_ram.sv
hw/page_walker.sv
hw/tlb.sv
hw/mmu_top.sv
dv/tb_mmu_top.sv

// ==== Makefile ====
# Verilator build and run of the MMU testbench
VERILATOR ?= verilator
TOP       ?= tb_mmu_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BUILD_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -o V$* -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "Test failures found" $(LOG); then echo "simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then echo "simulation did not finish"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
